// File: hw/neuronPkg.sv
package neuronPkg;

    //////////////////////////////
    // word and pool geometry
    //////////////////////////////

    // Q2.16 signed fixed point
    localparam int DATA_W = 18;
    // wide intermediate for products and sums
    localparam int WIDE_W = 40;
    localparam int IDX_W = 4;
    localparam int POOL_SIZE = 16;

    //////////////////////////////
    // izhikevich constants
    //////////////////////////////

    // a = 0.125 and b = 0.25 as right shifts
    localparam logic [3:0] PARAM_A_SHIFT = 4'd3;
    localparam logic [3:0] PARAM_B_SHIFT = 4'd2;
    // reset potential, -0.65
    localparam logic signed [DATA_W-1:0] PARAM_C = 18'sh3_599A;
    // recovery bump, 0.08
    localparam logic signed [DATA_W-1:0] PARAM_D = 18'sh0_147A;
    // spike threshold, 0.30
    localparam logic signed [DATA_W-1:0] V_PEAK = 18'sh0_4CCC;
    // dt = 1/4
    localparam logic [3:0] TAU_SHIFT = 4'd2;
    // synaptic jump, 1/16 of full scale
    localparam logic signed [DATA_W-1:0] SYN_JUMP = 18'sh0_2000;
    localparam logic [3:0] SYN_DECAY_SHIFT = 4'd4;

    // saturation bounds of one data word, held wide
    localparam logic signed [WIDE_W-1:0] DATA_MAX = WIDE_W'(2 ** (DATA_W - 1) - 1);
    localparam logic signed [WIDE_W-1:0] DATA_MIN = -DATA_MAX - 40'sd1;

    // clamp a wide result back into one data word
    function automatic logic signed [DATA_W-1:0] satData(input logic signed [WIDE_W-1:0] x);
        logic signed [DATA_W-1:0] y;
        if (x > DATA_MAX)
            y = DATA_MAX[DATA_W-1:0];
        else if (x < DATA_MIN)
            y = DATA_MIN[DATA_W-1:0];
        else
            y = x[DATA_W-1:0];
        return y;
    endfunction

endpackage

// File: hw/busPkg.sv
package busPkg;

    //////////////////////////////
    // wishbone geometry
    //////////////////////////////

    localparam int WB_ADDR_W = 4;
    localparam int WB_DATA_W = 32;

    //////////////////////////////
    // register map
    //////////////////////////////

    // read/write control registers
    localparam logic [WB_ADDR_W-1:0] REG_HALF_CNT = 4'h0;
    localparam logic [WB_ADDR_W-1:0] REG_RATE = 4'h1;
    localparam logic [WB_ADDR_W-1:0] REG_PPS_COEF = 4'h2;
    localparam logic [WB_ADDR_W-1:0] REG_GAIN = 4'h3;
    // read only, spikes clear on read
    localparam logic [WB_ADDR_W-1:0] REG_SPIKES = 4'h4;
    localparam logic [WB_ADDR_W-1:0] REG_SWEEPS = 4'h5;

    // divider value after reset
    localparam logic [WB_DATA_W-1:0] HALF_CNT_RESET = 32'd3;

endpackage

// File: hw/poolConfig.sv
`timescale 1ns/1ps

module poolConfig import neuronPkg::*, busPkg::*; (
    input  logic                 rawclk,
    input  logic                 rstN,
    input  logic                 wbCyc,
    input  logic                 wbStb,
    input  logic                 wbWe,
    input  logic [WB_ADDR_W-1:0] wbAdr,
    input  logic [WB_DATA_W-1:0] wbDatW,
    input  logic                 spikeIn,
    input  logic                 sweepDone,
    output logic [WB_DATA_W-1:0] wbDatR,
    output logic                 wbAck,
    output logic [31:0]          halfCnt,
    output logic [DATA_W-1:0]    afferentDrive,
    output logic [DATA_W-1:0]    gain
);

    logic [WB_DATA_W-1:0]   rate;
    logic [WB_DATA_W-1:0]   ppsCoef;
    logic [WB_DATA_W-1:0]   gainReg;
    logic [WB_DATA_W-1:0]   spikeCnt;
    logic [WB_DATA_W-1:0]   sweepCnt;
    logic [2*WB_DATA_W-1:0] driveProd;
    logic                   req;
    logic                   readSpikes;

    // new request, ack goes out next edge
    assign req = wbCyc & wbStb & ~wbAck;
    assign readSpikes = req & ~wbWe & (wbAdr == REG_SPIKES);
    assign gain = gainReg[DATA_W-1:0];

    // afferent drive = rate * coefficient, clamped to positive max
    always_comb begin
        driveProd = rate * ppsCoef;
        if (|driveProd[2*WB_DATA_W-1:DATA_W-1])
            afferentDrive = DATA_MAX[DATA_W-1:0];
        else
            afferentDrive = driveProd[DATA_W-1:0];
    end

    //////////////////////////////
    // control registers, counters
    //////////////////////////////

    always_ff @(posedge rawclk) begin
        if (!rstN) begin
            wbAck <= 1'b0;
            halfCnt <= HALF_CNT_RESET;
            rate <= '0;
            ppsCoef <= '0;
            gainReg <= '0;
            spikeCnt <= '0;
            sweepCnt <= '0;
        end else begin
            wbAck <= req;
            // writes land on the ack edge, read-only offsets dropped
            if (req && wbWe) begin
                case (wbAdr)
                    REG_HALF_CNT: halfCnt <= wbDatW;
                    REG_RATE:     rate <= wbDatW;
                    REG_PPS_COEF: ppsCoef <= wbDatW;
                    REG_GAIN:     gainReg <= wbDatW;
                    default:      ;
                endcase
            end
            // clear on read, a coincident spike still counts
            if (readSpikes)
                spikeCnt <= WB_DATA_W'(spikeIn);
            else
                spikeCnt <= spikeCnt + WB_DATA_W'(spikeIn);
            sweepCnt <= sweepCnt + WB_DATA_W'(sweepDone);
        end
    end

    // read data, valid together with ack
    always_ff @(posedge rawclk) begin
        if (req) begin
            case (wbAdr)
                REG_HALF_CNT: wbDatR <= halfCnt;
                REG_RATE:     wbDatR <= rate;
                REG_PPS_COEF: wbDatR <= ppsCoef;
                REG_GAIN:     wbDatR <= gainReg;
                REG_SPIKES:   wbDatR <= spikeCnt;
                REG_SWEEPS:   wbDatR <= sweepCnt;
                default:      wbDatR <= '0;
            endcase
        end
    end

endmodule

// File: hw/neuronSequencer.sv
`timescale 1ns/1ps

module neuronSequencer import neuronPkg::*; (
    input  logic             rawclk,
    input  logic             rstN,
    input  logic [31:0]      halfCnt,
    output logic             step,
    output logic [1:0]       phase,
    output logic [IDX_W-1:0] neuronIndex,
    output logic             sweepDone
);

    logic [31:0] divCnt;

    //////////////////////////////
    // update-rate divider
    //////////////////////////////

    // step once every halfCnt+1 cycles
    always_ff @(posedge rawclk) begin
        if (!rstN) begin
            divCnt <= '0;
            step <= 1'b0;
        end else if (divCnt == 32'd0) begin
            divCnt <= halfCnt;
            step <= 1'b1;
        end else begin
            divCnt <= divCnt - 32'd1;
            step <= 1'b0;
        end
    end

    //////////////////////////////
    // phase and neuron index
    //////////////////////////////

    // 0 fetch, 1 read, 2 compute, 3 write
    always_ff @(posedge rawclk) begin
        if (!rstN) begin
            phase <= 2'd0;
            neuronIndex <= '0;
            sweepDone <= 1'b0;
        end else begin
            // last neuron leaving its write phase
            sweepDone <= step && (phase == 2'd3) && (neuronIndex == IDX_W'(POOL_SIZE - 1));
            if (step) begin
                phase <= phase + 2'd1;
                // phase wrap moves to the next neuron
                if (phase == 2'd3) begin
                    if (neuronIndex == IDX_W'(POOL_SIZE - 1))
                        neuronIndex <= '0;
                    else
                        neuronIndex <= neuronIndex + 1'b1;
                end
            end
        end
    end

endmodule

// File: hw/izhNeuron.sv
`timescale 1ns/1ps

module izhNeuron import neuronPkg::*; (
    input  logic                     rawclk,
    input  logic                     rstN,
    input  logic                     step,
    input  logic [1:0]               phase,
    input  logic [IDX_W-1:0]         neuronIndex,
    input  logic signed [DATA_W-1:0] current,
    output logic                     spike
);

    // per-neuron membrane potential and recovery
    logic signed [DATA_W-1:0] vMem [POOL_SIZE];
    logic signed [DATA_W-1:0] uMem [POOL_SIZE];

    logic [IDX_W-1:0]         addr;
    logic signed [DATA_W-1:0] vCur;
    logic signed [DATA_W-1:0] uCur;
    logic signed [DATA_W-1:0] vNext;
    logic signed [DATA_W-1:0] uNext;
    logic                     fired;

    logic signed [WIDE_W-1:0] vSq;
    logic signed [WIDE_W-1:0] dv;
    logic signed [WIDE_W-1:0] du;
    logic signed [WIDE_W-1:0] vSum;
    logic signed [WIDE_W-1:0] uSum;
    logic signed [WIDE_W-1:0] uBump;

    //////////////////////////////
    // euler step, all wide
    //////////////////////////////

    always_comb begin
        // Q4.32 square
        vSq = vCur * vCur;
        // >>16 back to Q2.16, <<2 for the factor 4
        dv = (vSq >>> 14) + vCur - uCur + current;
        vSum = vCur + (dv >>> TAU_SHIFT);
        // a * (b*v - u)
        du = ((vCur >>> PARAM_B_SHIFT) - uCur) >>> PARAM_A_SHIFT;
        uSum = uCur + (du >>> TAU_SHIFT);
        // recovery after a spike
        uBump = uNext + PARAM_D;
    end

    // spike presented for the whole write slot
    assign spike = fired && (phase == 2'd3);

    //////////////////////////////
    // four-phase update
    //////////////////////////////

    always_ff @(posedge rawclk) begin
        if (!rstN) begin
            for (int i = 0; i < POOL_SIZE; i++) begin
                vMem[i] <= PARAM_C;
                uMem[i] <= '0;
            end
            fired <= 1'b0;
        end else if (step) begin
            case (phase)
                // latch the neuron address
                2'd0: addr <= neuronIndex;
                // pull state out of memory
                2'd1: begin
                    vCur <= vMem[addr];
                    uCur <= uMem[addr];
                end
                // compute and test threshold
                2'd2: begin
                    vNext <= satData(vSum);
                    uNext <= satData(uSum);
                    fired <= (vSum >= V_PEAK);
                end
                // write back, reset on spike
                default: begin
                    if (fired) begin
                        vMem[addr] <= PARAM_C;
                        uMem[addr] <= satData(uBump);
                    end else begin
                        vMem[addr] <= vNext;
                        uMem[addr] <= uNext;
                    end
                end
            endcase
        end
    end

endmodule

// File: hw/synapseDecay.sv
`timescale 1ns/1ps

module synapseDecay import neuronPkg::*; (
    input  logic                     rawclk,
    input  logic                     rstN,
    input  logic                     step,
    input  logic [1:0]               phase,
    input  logic [IDX_W-1:0]         neuronIndex,
    input  logic                     spikeIn,
    output logic signed [DATA_W-1:0] current
);

    // one postsynaptic current per neuron
    logic signed [DATA_W-1:0] curMem [POOL_SIZE];

    logic [IDX_W-1:0]         addr;
    logic signed [DATA_W-1:0] curReg;
    logic signed [DATA_W-1:0] jump;
    logic signed [WIDE_W-1:0] curSum;

    // decay by 1/16 then add the jump on a spike
    always_comb begin
        jump = spikeIn ? SYN_JUMP : '0;
        curSum = curReg - (curReg >>> SYN_DECAY_SHIFT) + jump;
    end

    // value read in phase 1, seen by the motoneuron compute
    assign current = curReg;

    //////////////////////////////
    // read phase 1, write phase 3
    //////////////////////////////

    always_ff @(posedge rawclk) begin
        if (!rstN) begin
            for (int i = 0; i < POOL_SIZE; i++) begin
                curMem[i] <= '0;
            end
            curReg <= '0;
        end else if (step) begin
            case (phase)
                2'd0: addr <= neuronIndex;
                2'd1: curReg <= curMem[addr];
                // new spike only shows up next sweep
                2'd3: curMem[addr] <= satData(curSum);
                default: ;
            endcase
        end
    end

endmodule

// File: hw/neuronPool.sv
`timescale 1ns/1ps

module neuronPool import neuronPkg::*, busPkg::*; (
    input  logic                 rawclk,
    input  logic                 rstN,
    input  logic                 wbCyc,
    input  logic                 wbStb,
    input  logic                 wbWe,
    input  logic [WB_ADDR_W-1:0] wbAdr,
    input  logic [WB_DATA_W-1:0] wbDatW,
    output logic [WB_DATA_W-1:0] wbDatR,
    output logic                 wbAck,
    output logic                 mnSpike
);

    logic [31:0]              halfCnt;
    logic [DATA_W-1:0]        afferentDrive;
    logic [DATA_W-1:0]        gain;
    logic                     step;
    logic [1:0]               phase;
    logic [IDX_W-1:0]         neuronIndex;
    logic                     sweepDone;
    logic                     iaSpike;
    logic                     mnRaw;
    logic signed [DATA_W-1:0] synCurrent;
    logic signed [DATA_W-1:0] mnDrive;
    logic signed [WIDE_W-1:0] gainProd;

    // integer gain on the synaptic current, clamped
    assign gainProd = synCurrent * $signed({1'b0, gain});
    assign mnDrive = satData(gainProd);

    // only the write step of a motoneuron counts
    assign mnSpike = mnRaw & step & (phase == 2'd3);

    //////////////////////////////
    // host registers and timing
    //////////////////////////////

    poolConfig uConfig (
        .rawclk(rawclk), .rstN(rstN),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW),
        .spikeIn(mnSpike), .sweepDone(sweepDone),
        .wbDatR(wbDatR), .wbAck(wbAck),
        .halfCnt(halfCnt), .afferentDrive(afferentDrive), .gain(gain)
    );

    neuronSequencer uSequencer (
        .rawclk(rawclk), .rstN(rstN), .halfCnt(halfCnt),
        .step(step), .phase(phase), .neuronIndex(neuronIndex), .sweepDone(sweepDone)
    );

    //////////////////////////////
    // Ia -> synapse -> motoneuron
    //////////////////////////////

    izhNeuron uIaNeuron (
        .rawclk(rawclk), .rstN(rstN), .step(step), .phase(phase),
        .neuronIndex(neuronIndex), .current($signed(afferentDrive)), .spike(iaSpike)
    );

    synapseDecay uSynapse (
        .rawclk(rawclk), .rstN(rstN), .step(step), .phase(phase),
        .neuronIndex(neuronIndex), .spikeIn(iaSpike), .current(synCurrent)
    );

    izhNeuron uMotoNeuron (
        .rawclk(rawclk), .rstN(rstN), .step(step), .phase(phase),
        .neuronIndex(neuronIndex), .current(mnDrive), .spike(mnRaw)
    );

endmodule

// File: verification/neuronPool_assert.sv
`timescale 1ns/1ps

module neuronPoolAssert (
    input logic        rawclk,
    input logic        rstN,
    input logic        wbCyc,
    input logic        wbStb,
    input logic        wbAck,
    input logic        step,
    input logic [1:0]  phase,
    input logic [31:0] halfCnt,
    input logic        mnSpike
);

    //////////////////////////////
    // bus handshake
    //////////////////////////////

    // request answered on the next edge
    ackFollowsRequest: assert property (@(posedge rawclk) disable iff (!rstN)
        (wbCyc && wbStb && !wbAck) |=> wbAck)
        else $error("wbAck missing after a request");

    // ack is a single-cycle pulse
    ackSingleCycle: assert property (@(posedge rawclk) disable iff (!rstN)
        wbAck |=> !wbAck)
        else $error("wbAck held longer than one cycle");

    //////////////////////////////
    // sequencer timing
    //////////////////////////////

    // divider of 1 or more spaces the steps
    stepSpacing: assert property (@(posedge rawclk) disable iff (!rstN)
        (step && halfCnt >= 32'd1) |=> !step)
        else $error("step high on consecutive cycles");

    // spike leaves in phase 3 on its step, so the phase wraps right after
    spikeInWritePhase: assert property (@(posedge rawclk) disable iff (!rstN)
        mnSpike |=> ($past(phase) == 2'd3) && (phase == 2'd0))
        else $error("mnSpike outside the phase 3 step");

endmodule

bind neuronPool neuronPoolAssert uChecker (
    .rawclk(rawclk), .rstN(rstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbAck(wbAck),
    .step(step), .phase(phase), .halfCnt(halfCnt), .mnSpike(mnSpike)
);

// File: verification/neuronPoolTb.sv
`timescale 1ns/1ps

module neuronPoolTb import busPkg::*;;

    logic                 rawclk;
    logic                 rstN;
    logic                 wbCyc;
    logic                 wbStb;
    logic                 wbWe;
    logic [WB_ADDR_W-1:0] wbAdr;
    logic [WB_DATA_W-1:0] wbDatW;
    logic [WB_DATA_W-1:0] wbDatR;
    logic                 wbAck;
    logic                 mnSpike;

    int          errorCount;
    int          testPass;
    int          testFail;
    int          mnCount;
    bit          timedOut;
    bit          spuriousAck;
    bit          reqPrev;
    logic [31:0] lfsrState;

    neuronPool u_dut (
        .rawclk(rawclk), .rstN(rstN),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW),
        .wbDatR(wbDatR), .wbAck(wbAck), .mnSpike(mnSpike)
    );

    // 100 ns period
    always #50 rawclk = ~rawclk;

    // ack must follow a request seen on the edge before
    always @(posedge rawclk) begin
        if (rstN && wbAck && !reqPrev)
            spuriousAck = 1'b1;
        reqPrev = wbCyc && wbStb && !wbAck;
    end

    // motoneuron pulses on the output pin, one cycle wide
    always @(negedge rawclk) begin
        if (rstN && mnSpike)
            mnCount++;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic randomWord(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsrState = lfsrNext(lfsrState);
            w = {w[30:0], lfsrState[0]};
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s actual=%0h expected=%0h", $time, name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic applyReset();
        rstN = 1'b0;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        repeat (8) @(negedge rawclk);
        rstN = 1'b1;
    endtask

    // single classic cycle, ack sampled on the falling edge
    task automatic busAccess(input logic we, input logic [WB_ADDR_W-1:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waitCount;
        rdata = '0;
        if (timedOut)
            return;
        @(negedge rawclk);
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = we;
        wbAdr = adr;
        wbDatW = wdata;
        waitCount = 0;
        do begin
            @(negedge rawclk);
            waitCount++;
        end while (!wbAck && waitCount < 20);
        if (!wbAck) begin
            $display("bus access to offset %0h was not acknowledged within 20 cycles", adr);
            timedOut = 1'b1;
        end
        rdata = wbDatR;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
    endtask

    task automatic busWrite(input logic [WB_ADDR_W-1:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        busAccess(1'b1, adr, data, unused);
    endtask

    task automatic busRead(input logic [WB_ADDR_W-1:0] adr, output logic [31:0] data);
        busAccess(1'b0, adr, '0, data);
    endtask

    // poll the sweep counter until it reaches the target
    // back-to-back polls two cycles apart, so the time between two
    // counter changes is one whole sweep
    task automatic waitSweeps(input logic [31:0] target, input logic [31:0] half,
                              output logic [31:0] observed, output int periodCycles);
        int          pollLimit;
        int          polls;
        logic [31:0] previous;
        time         lastChange;
        bit          changeSeen;
        pollLimit = int'(target) * 64 * (int'(half) + 1) + 100;
        polls = 0;
        observed = '0;
        previous = '0;
        lastChange = 0;
        changeSeen = 1'b0;
        periodCycles = 0;
        do begin
            busRead(REG_SWEEPS, observed);
            polls++;
            if (!timedOut && observed != previous) begin
                if (changeSeen)
                    periodCycles = int'(($time - lastChange) / 100);
                lastChange = $time;
                changeSeen = 1'b1;
                previous = observed;
            end
        end while (observed < target && polls < pollLimit && !timedOut);
        if (observed < target && !timedOut) begin
            $display("sweep counter stuck at %0d while waiting for %0d sweeps", observed, target);
            timedOut = 1'b1;
        end
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore && !timedOut) begin
            $display("test %s: ok", name);
            testPass++;
        end else begin
            $display("test %s: mismatch or timeout", name);
            testFail++;
        end
    endtask

    // config before the first compute phase, divider last
    task automatic runCase(input logic [31:0] code, input logic [31:0] half,
                           input logic [31:0] rate, input logic [31:0] coef,
                           input logic [31:0] gain, input logic [31:0] sweeps,
                           input logic [31:0] expected);
        int          errorsBefore;
        int          period;
        logic [31:0] value;
        errorsBefore = errorCount;
        applyReset();
        mnCount = 0;
        busWrite(REG_RATE, rate);
        busWrite(REG_PPS_COEF, coef);
        busWrite(REG_GAIN, gain);
        busWrite(REG_HALF_CNT, half);
        waitSweeps(sweeps, half, value, period);
        checkValue("REG_SWEEPS", value, sweeps);
        // one sweep is 64 steps of halfCnt+1 cycles, first sweep skipped
        if (sweeps >= 32'd2)
            checkValue("sweep period", 32'(period), 32'd64 * (half + 32'd1));
        checkValue("mnSpike count", 32'(mnCount), expected);
        busRead(REG_SPIKES, value);
        checkValue("REG_SPIKES", value, expected);
        // cleared by the read above
        busRead(REG_SPIKES, value);
        checkValue("REG_SPIKES reread", value, 32'd0);
        finishTest($sformatf("case %02h", code), errorsBefore);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        logic [31:0] value;
        logic [31:0] written [4];
        logic [31:0] caseField [7];
        int          errorsBefore;
        int          fd;
        int          nFields;
        string       line;

        rawclk = 1'b0;
        rstN = 1'b0;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatW = '0;
        errorCount = 0;
        testPass = 0;
        testFail = 0;
        mnCount = 0;
        timedOut = 1'b0;
        spuriousAck = 1'b0;
        reqPrev = 1'b0;
        lfsrState = 32'h23f4_fed6;

        // reset values
        applyReset();
        errorsBefore = errorCount;
        busRead(REG_HALF_CNT, value);
        checkValue("REG_HALF_CNT", value, 32'd3);
        busRead(REG_RATE, value);
        checkValue("REG_RATE", value, 32'd0);
        busRead(REG_PPS_COEF, value);
        checkValue("REG_PPS_COEF", value, 32'd0);
        busRead(REG_GAIN, value);
        checkValue("REG_GAIN", value, 32'd0);
        busRead(REG_SPIKES, value);
        checkValue("REG_SPIKES", value, 32'd0);
        busRead(REG_SWEEPS, value);
        checkValue("REG_SWEEPS", value, 32'd0);
        checkValue("spuriousAck", 32'(spuriousAck), 32'd0);
        finishTest("reset values", errorsBefore);

        // random readback, offsets 0..3
        errorsBefore = errorCount;
        for (int i = 0; i < 4; i++) begin
            randomWord(written[i]);
            busWrite(WB_ADDR_W'(i), written[i]);
        end
        for (int i = 0; i < 4; i++) begin
            busRead(WB_ADDR_W'(i), value);
            checkValue($sformatf("register %0d", i), value, written[i]);
        end
        // read-only and undefined offsets
        applyReset();
        busWrite(REG_SPIKES, 32'hFFFF_FFFF);
        busWrite(REG_SWEEPS, 32'hFFFF_FFFF);
        busRead(REG_SPIKES, value);
        checkValue("REG_SPIKES", value, 32'd0);
        busRead(REG_SWEEPS, value);
        checkValue("REG_SWEEPS", value, 32'd0);
        busWrite(4'h9, 32'h1234_5678);
        busRead(4'h9, value);
        checkValue("offset 9", value, 32'd0);
        finishTest("register readback", errorsBefore);

        // spike cases from the data file
        fd = $fopen("verification/poolCases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file verification/poolCases.txt");
            errorCount++;
        end else begin
            while (!$feof(fd) && !timedOut) begin
                line = "";
                nFields = $fgets(line, fd);
                if (line.len() > 0 && line[0] != "#") begin
                    nFields = $sscanf(line, "%h %d %d %d %d %d %d", caseField[0],
                                      caseField[1], caseField[2], caseField[3],
                                      caseField[4], caseField[5], caseField[6]);
                    if (nFields == 7)
                        runCase(caseField[0], caseField[1], caseField[2], caseField[3],
                                caseField[4], caseField[5], caseField[6]);
                end
            end
            $fclose(fd);
        end

        $display("tests passed: %0d, tests failed: %0d", testPass, testFail);
        if (errorCount == 0 && testFail == 0 && !timedOut)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// File: verification/poolCases.txt
# columns: code halfCnt rate ppsCoef gain sweeps expectedSpikes
# code is hex, the rest decimal; every neuron of a pool behaves alike
# so expected counts are 16 times the spikes of one motoneuron
#
# rate zero, no drive anywhere
01 3 0 0 0 8 0
02 3 0 200 64 12 0
# saturated drive, motoneuron fires at updates 3, 5, 7
03 3 1000 200 64 8 48
# saturated drive, fires at updates 3, 5, 7, 9, 11
04 3 1000 200 64 12 80
# slower divider, same count
05 7 1000 200 64 12 80
06 5 2000 100 64 8 48
# same saturated drive from a smaller gain
08 3 500 400 32 12 80
# no gain, motoneuron stays at rest
07 3 1000 200 0 12 0

// File: flist.f
hw/neuronPkg.sv
hw/busPkg.sv
hw/poolConfig.sv
hw/neuronSequencer.sv
hw/izhNeuron.sv
hw/synapseDecay.sv
hw/neuronPool.sv
verification/neuronPool_assert.sv
verification/neuronPoolTb.sv

// File: Makefile
VERILATOR ?= verilator
FLIST     ?= flist.f
TOP       ?= neuronPoolTb
BUILD_DIR ?= obj_dir
PASS_MSG  ?= Regression passed
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
